/* Makefile */
# Verilator build for the frequency meter testbench
VERILATOR ?= verilator
TOP       ?= freq_meter_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal
JOBS      ?= 4

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* common/freq_meter_params.svh */
/*
 * Sizing macros for the two-channel frequency meter.
 * Include wherever channel count, counter width or bank address width is needed.
 */
`ifndef FREQ_METER_PARAMS_SVH
`define FREQ_METER_PARAMS_SVH

// number of measured square-wave inputs
`define FM_CHANNELS 2

// window counter width, counts pll_clk cycles per window
`define FM_CNT_W 32

// bank address: channel in msb, word index in low two bits
`define FM_ADR_W 3

`endif

/* common/freq_meter_pkg.sv */
/*
 * Types shared by the measurers, the arbiter, the result bank and the testbench.
 * Holds the Wishbone classic request/response structs and the bank word decodes.
 */
`include "freq_meter_params.svh"

package freq_meter_pkg;

    // request side of a wishbone classic cycle
    typedef struct packed {
        logic                 cyc;                  // cycle in progress
        logic                 stb;                  // strobe, valid transfer
        logic                 we;                   // 1 = write
        logic [`FM_ADR_W-1:0] adr;                  // {ch, word index}
        logic [31:0]          dat;                  // write data
    } wb_req_t;

    // response side
    typedef struct packed {
        logic        ack;                           // single-cycle ack
        logic [31:0] dat;                           // read data, valid with ack
    } wb_rsp_t;

    // word 2 of a channel slot
    typedef struct packed {
        logic [15:0] seq;                           // posted result count
        logic        ovf;                           // a result was dropped before this one
        logic        high_seen;                     // input was high inside the window
        logic        ch;                            // channel that posted it
        logic [12:0] spare;                         // reads zero
    } meas_status_t;

    // one bank word, raw count for words 0/1, status for word 2
    typedef union packed {
        logic [31:0]  count;
        meas_status_t status;
    } meas_word_u;

    // snapshot held while posting
    typedef struct packed {
        logic [`FM_CNT_W-1:0] period_total;         // N x period, pll_clk cycles
        logic [`FM_CNT_W-1:0] high_total;           // N x high time, pll_clk cycles
    } meas_result_t;

endpackage

/* design/freq_meter_top.sv */
/*
 * Two-channel square-wave frequency and duty meter.
 * Measurers share the result bank through a round-robin Wishbone arbiter,
 * and the host reads counts and status through its own Wishbone port.
 */
`timescale 1ns/100ps
`include "freq_meter_params.svh"

module freq_meter_top import freq_meter_pkg::*; (
    input  logic                    pll_clk,
    input  logic                    sys_rst_n,
    input  logic [`FM_CHANNELS-1:0] wave_in,                // one bit per channel
    input  logic [15:0]             edge_count,             // periods per window
    input  wb_req_t                 host_req,
    output wb_rsp_t                 host_rsp
);

    wb_req_t mst_req [`FM_CHANNELS];                        // measurer -> arbiter
    wb_rsp_t mst_rsp [`FM_CHANNELS];
    wb_req_t slv_req;                                       // arbiter -> bank
    wb_rsp_t slv_rsp;

    for (genvar i = 0; i < `FM_CHANNELS; i++) begin : g_ch
        period_counter #(
            .CH         (i)
        ) u_period_counter (
            .pll_clk    (pll_clk),
            .sys_rst_n  (sys_rst_n),
            .wave       (wave_in[i]),
            .edge_count (edge_count),
            .bus_req    (mst_req[i]),
            .bus_rsp    (mst_rsp[i])
        );
    end

    wb_arbiter u_wb_arbiter (
        .pll_clk    (pll_clk),
        .sys_rst_n  (sys_rst_n),
        .mst_req    (mst_req),
        .mst_rsp    (mst_rsp),
        .slv_req    (slv_req),
        .slv_rsp    (slv_rsp)
    );

    result_bank u_result_bank (
        .pll_clk    (pll_clk),
        .sys_rst_n  (sys_rst_n),
        .bus_req    (slv_req),
        .bus_rsp    (slv_rsp),
        .host_req   (host_req),
        .host_rsp   (host_rsp)
    );

endmodule

/* design/result_bank.sv */
/*
 * Result register file, one slot of three words per channel.
 * Written from the shared bus by the measurers, read by the host on its own port.
 */
`timescale 1ns/100ps
`include "freq_meter_params.svh"

module result_bank import freq_meter_pkg::*; (
    input  logic    pll_clk,
    input  logic    sys_rst_n,
    input  wb_req_t bus_req,                                // shared bus from arbiter
    output wb_rsp_t bus_rsp,
    input  wb_req_t host_req,                               // host, read only
    output wb_rsp_t host_rsp
);

    localparam int DEPTH = 2 ** `FM_ADR_W;

    meas_word_u  bank [DEPTH];                              // {ch, idx} addressed
    logic        bus_ack;
    logic        host_ack;
    meas_word_u  host_dat;
    logic        bus_hit;
    logic        host_hit;

    // new access only, so each ack lasts one cycle
    assign bus_hit  = bus_req.cyc & bus_req.stb & ~bus_ack;
    assign host_hit = host_req.cyc & host_req.stb & ~host_ack;

    // write lands on the edge that raises ack
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            bus_ack <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                bank[i] <= '0;                              // seq reads 0 after reset
            end
        end else begin
            bus_ack <= bus_hit;
            if (bus_hit && bus_req.we) begin
                bank[bus_req.adr].count <= bus_req.dat;
            end
        end
    end

    // host reads on a path of its own
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            host_ack <= 1'b0;
        end else begin
            host_ack <= host_hit;                           // host we ignored
        end
    end

    always_ff @(posedge pll_clk) begin
        if (host_hit) begin
            host_dat <= bank[host_req.adr];                 // valid with ack
        end
    end

    assign bus_rsp.ack  = bus_ack;
    assign bus_rsp.dat  = '0;                               // measurers only write
    assign host_rsp.ack = host_ack;
    assign host_rsp.dat = host_dat.count;

endmodule

/* design/wb_arbiter.sv */
/*
 * Round-robin arbiter for the shared Wishbone classic bus into the result bank.
 * The grant is held for a whole cycle and moves after ack or when cyc drops.
 */
`timescale 1ns/100ps
`include "freq_meter_params.svh"

module wb_arbiter import freq_meter_pkg::*; (
    input  logic    pll_clk,
    input  logic    sys_rst_n,
    input  wb_req_t mst_req [`FM_CHANNELS],
    output wb_rsp_t mst_rsp [`FM_CHANNELS],
    output wb_req_t slv_req,
    input  wb_rsp_t slv_rsp
);

    localparam int IDX_W = (`FM_CHANNELS > 1) ? $clog2(`FM_CHANNELS) : 1;

    logic [`FM_CHANNELS-1:0] req_vec;                       // cyc & stb per master
    logic [`FM_CHANNELS-1:0] grant;                         // one-hot or idle
    logic [`FM_CHANNELS-1:0] grant_nxt;
    logic [IDX_W-1:0]        last;                          // last granted master
    logic [IDX_W-1:0]        last_nxt;

    always_comb begin
        for (int i = 0; i < `FM_CHANNELS; i++) begin
            req_vec[i] = mst_req[i].cyc & mst_req[i].stb;
        end
    end

    always_comb begin : pick
        int   idx;
        logic found;
        grant_nxt = grant;
        last_nxt  = last;
        found     = 1'b0;
        idx       = 0;
        if (grant == '0) begin
            // search starts just after the last winner
            for (int i = 1; i <= `FM_CHANNELS; i++) begin
                idx = (int'(last) + i) % `FM_CHANNELS;
                if (!found && req_vec[idx]) begin
                    found          = 1'b1;
                    grant_nxt      = '0;
                    grant_nxt[idx] = 1'b1;
                    last_nxt       = IDX_W'(idx);
                end
            end
        end else if (slv_rsp.ack) begin
            if (|(req_vec & ~grant)) begin
                grant_nxt = '0;                             // hand over, rearbitrate
            end
        end else if (!slv_req.cyc) begin
            grant_nxt = '0;                                 // owner went away
        end
    end

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            grant <= '0;
            last  <= IDX_W'(`FM_CHANNELS - 1);              // master 0 wins first
        end else begin
            grant <= grant_nxt;
            last  <= last_nxt;
        end
    end

    // forward granted request, ack back to owner only
    always_comb begin
        slv_req = '0;
        for (int i = 0; i < `FM_CHANNELS; i++) begin
            mst_rsp[i] = '0;
            if (grant[i]) begin
                slv_req    = mst_req[i];
                mst_rsp[i] = slv_rsp;
            end
        end
    end

endmodule

/* measure/period_counter.sv */
/*
 * One measurement channel: syncs the input, finds rising edges and counts a window
 * of edge_count periods. Each closed window is posted to the result bank as three
 * Wishbone classic writes: period total, high total, then the status word.
 */
`timescale 1ns/100ps
`include "freq_meter_params.svh"

module period_counter import freq_meter_pkg::*; #(
    parameter int CH = 0                                    // channel number
) (
    input  logic        pll_clk,
    input  logic        sys_rst_n,
    input  logic        wave,                               // async square wave
    input  logic [15:0] edge_count,                         // periods per window
    output wb_req_t     bus_req,
    input  wb_rsp_t     bus_rsp
);

    localparam logic CH_BIT = 1'(CH);                       // adr msb and status ch

    logic                 wave_meta;                        // first sync flop
    logic                 wave_sync;                        // second sync flop
    logic                 wave_dly;                         // edge register
    logic                 rise;
    logic                 win_open;
    logic                 win_close;
    logic [15:0]          win_len;                          // N sampled at window open
    logic [15:0]          edges_seen;                       // rises since opening edge
    logic [`FM_CNT_W-1:0] period_cnt;
    logic [`FM_CNT_W-1:0] high_cnt;
    meas_result_t         snap;                             // result being posted
    logic                 snap_ovf;
    logic                 high_seen;
    logic                 ovf_pend;                         // drop waiting to be reported
    logic [15:0]          seq;
    logic                 busy;                             // posting in progress
    logic [1:0]           word_idx;                         // 0 period, 1 high, 2 status
    meas_status_t         status;
    meas_word_u           post_word;

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            {wave_meta, wave_sync, wave_dly} <= 3'b000;
        end else begin
            {wave_meta, wave_sync, wave_dly} <= {wave, wave_meta, wave_sync};
        end
    end

    assign rise      = wave_sync & ~wave_dly;                           // same lag on every edge
    assign win_close = rise & win_open & (edges_seen + 16'd1 == win_len);   // N-th rise

    // window counters, closing edge reopens at once
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            win_open   <= 1'b0;
            win_len    <= 16'd1;
            edges_seen <= 16'd0;
            period_cnt <= '0;
            high_cnt   <= '0;
        end else if (rise && (!win_open || win_close)) begin
            win_open   <= 1'b1;
            win_len    <= (edge_count == 16'd0) ? 16'd1 : edge_count;  // min 1 period
            edges_seen <= 16'd0;
            period_cnt <= `FM_CNT_W'(1);                    // opening cycle counts
            high_cnt   <= `FM_CNT_W'(1);                    // input is high on a rise
        end else if (win_open) begin
            period_cnt <= period_cnt + 1'b1;
            if (wave_sync) begin
                high_cnt <= high_cnt + 1'b1;
            end
            if (rise) begin
                edges_seen <= edges_seen + 16'd1;
            end
        end
    end

    // snapshot payload, taken only when the poster is free
    always_ff @(posedge pll_clk) begin
        if (win_close && !busy) begin
            snap.period_total <= period_cnt;
            snap.high_total   <= high_cnt;
        end
    end

    // poster fsm: idle -> word 0 -> word 1 -> word 2 -> idle
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            busy      <= 1'b0;
            word_idx  <= 2'd0;
            seq       <= 16'd0;
            ovf_pend  <= 1'b0;
            snap_ovf  <= 1'b0;
            high_seen <= 1'b0;
        end else begin
            if (win_close && !busy) begin
                busy      <= 1'b1;
                word_idx  <= 2'd0;
                seq       <= seq + 16'd1;
                snap_ovf  <= ovf_pend;                      // report earlier drop
                ovf_pend  <= 1'b0;
                high_seen <= (high_cnt != '0);
            end else if (busy && bus_rsp.ack) begin
                if (word_idx == 2'd2) begin
                    busy <= 1'b0;                           // status written, done
                end else begin
                    word_idx <= word_idx + 2'd1;
                end
            end
            if (win_close && busy) begin
                ovf_pend <= 1'b1;                           // result lost, still posting
            end
        end
    end

    always_comb begin
        status           = '0;
        status.seq       = seq;
        status.ovf       = snap_ovf;
        status.high_seen = high_seen;
        status.ch        = CH_BIT;
        case (word_idx)
            2'd0:    post_word.count  = snap.period_total;
            2'd1:    post_word.count  = snap.high_total;
            default: post_word.status = status;             // status goes last
        endcase
    end

    // request held from fsm state until ack
    assign bus_req.cyc = busy;
    assign bus_req.stb = busy;
    assign bus_req.we  = busy;
    assign bus_req.adr = {CH_BIT, word_idx};
    assign bus_req.dat = post_word.count;

endmodule

/* tb.f */
+incdir+common
common/freq_meter_pkg.sv
measure/period_counter.sv
design/wb_arbiter.sv
design/result_bank.sv
design/freq_meter_top.sv
verif/freq_meter_checker.sv
verif/freq_meter_tb.sv

/* verif/freq_meter_checker.sv */
/*
 * Assertions on the shared result bus, bound into every wb_arbiter.
 * Covers grant encoding, ack qualification, request hold and ack routing.
 */
`timescale 1ns/100ps
`include "freq_meter_params.svh"

module freq_meter_checker import freq_meter_pkg::*; (
    input logic                    pll_clk,
    input logic                    sys_rst_n,
    input logic [`FM_CHANNELS-1:0] grant,
    input wb_req_t                 mst_req [`FM_CHANNELS],
    input wb_rsp_t                 mst_rsp [`FM_CHANNELS],
    input wb_req_t                 slv_req,
    input wb_rsp_t                 slv_rsp
);

    int fail_count = 0;                                     // failed assertions so far

    a_grant_onehot: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        $onehot0(grant))
        else begin
            fail_count = fail_count + 1;
            $error("arbiter grant has more than one bit set");
        end

    a_ack_in_cycle: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        slv_rsp.ack |-> (slv_req.cyc && slv_req.stb))
        else begin
            fail_count = fail_count + 1;
            $error("bank ack seen outside a bus cycle");
        end

    for (genvar i = 0; i < `FM_CHANNELS; i++) begin : g_mst
        // master holds adr, dat and we until acked
        a_req_stable: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
            (mst_req[i].cyc && mst_req[i].stb && !mst_rsp[i].ack) |=> $stable(mst_req[i]))
            else begin
                fail_count = fail_count + 1;
                $error("master request changed before its ack");
            end

        a_ack_owner: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
            mst_rsp[i].ack |-> grant[i])
            else begin
                fail_count = fail_count + 1;
                $error("ack routed to a master without grant");
            end
    end

endmodule

bind wb_arbiter freq_meter_checker u_checker (
    .pll_clk   (pll_clk),
    .sys_rst_n (sys_rst_n),
    .grant     (grant),
    .mst_req   (mst_req),
    .mst_rsp   (mst_rsp),
    .slv_req   (slv_req),
    .slv_rsp   (slv_rsp)
);

/* verif/freq_meter_tb.sv */
/*
 * Testbench for the two-channel frequency meter. A table of wave shapes and
 * window lengths is applied in a loop; results are read back over the host port.
 */
`timescale 1ns/100ps
`include "freq_meter_params.svh"

module freq_meter_tb import freq_meter_pkg::*;;

    localparam int N_ROWS = 6;

    logic                    pll_clk = 1'b0;
    logic                    sys_rst_n;
    logic [`FM_CHANNELS-1:0] wave_in;
    logic [15:0]             edge_count;
    wb_req_t                 host_req;
    wb_rsp_t                 host_rsp;

    // name, {per0, per1}, {high0, high1}, edge_count
    string row_name [N_ROWS] = '{"duty50_equal", "duty10", "duty90",
                                 "diff_freq", "edge_count_1", "edge_count_16"};
    int    row_per  [N_ROWS][2] = '{'{40, 40}, '{100, 60}, '{50, 80},
                                    '{40, 400}, '{40, 64}, '{48, 72}};
    int    row_high [N_ROWS][2] = '{'{20, 20}, '{10, 6}, '{45, 72},
                                    '{20, 100}, '{4, 32}, '{24, 36}};
    int    row_ec   [N_ROWS] = '{4, 2, 3, 2, 1, 16};

    int    cur_per  [2];                                    // live generator shape
    int    cur_high [2];
    int    last_seq [2];                                    // last seq seen per channel
    logic  gen_go;
    int unsigned rnd;

    freq_meter_top UUT (
        .pll_clk    (pll_clk),
        .sys_rst_n  (sys_rst_n),
        .wave_in    (wave_in),
        .edge_count (edge_count),
        .host_req   (host_req),
        .host_rsp   (host_rsp)
    );

    always #10 pll_clk = ~pll_clk;                          // 20 ns period

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_count(input string name, input meas_word_u act,
                               input logic [31:0] exp);
        if (act.count !== exp) begin
            fail_run($sformatf("mismatch %s: expected %0d actual %0d", name, exp, act.count));
        end
    endtask

    task automatic check_status(input string name, input meas_status_t act,
                                input logic exp_ch, input logic exp_ovf, input logic exp_high);
        if (act.ch !== exp_ch || act.ovf !== exp_ovf || act.high_seen !== exp_high) begin
            fail_run({$sformatf("mismatch %s: expected ch %0d ovf %0d high_seen %0d",
                                name, exp_ch, exp_ovf, exp_high),
                      $sformatf(" actual ch %0d ovf %0d high_seen %0d",
                                act.ch, act.ovf, act.high_seen)});
        end
    endtask

    // wishbone classic single read with data taken at ack
    task automatic host_read(input logic [2:0] adr, output meas_word_u word);
        wb_req_t req;
        int      waited;
        logic    got;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.adr = adr;
        waited  = 0;
        got     = 1'b0;
        @(posedge pll_clk);
        host_req <= req;
        while (!got) begin
            @(negedge pll_clk);                             // ack is stable here
            got = host_rsp.ack;
            waited++;
            if (waited > 16) begin
                fail_run("host read was never acknowledged by the bank");
            end
        end
        word = host_rsp.dat;
        @(posedge pll_clk);
        host_req <= '0;
    endtask

    // seq may only hold or step by one between polls
    task automatic note_seq(input int ch, input logic [15:0] seq, input string name);
        if (seq != 16'(last_seq[ch]) && seq != 16'(last_seq[ch] + 1)) begin
            fail_run($sformatf("mismatch %s ch%0d seq: expected %0d actual %0d",
                               name, ch, last_seq[ch] + 1, seq));
        end
        last_seq[ch] = seq;
    endtask

    task automatic poll_status(input int ch, input string name);
        meas_word_u w;
        host_read({1'(ch), 2'd2}, w);
        note_seq(ch, w.status.seq, name);
    endtask

    task automatic read_slot(input int r, input int ch);
        int         order [3];
        int         j;
        int         t;
        meas_word_u words [3];
        string      name;
        name  = $sformatf("%s ch%0d", row_name[r], ch);
        order = '{0, 1, 2};
        for (int i = 2; i > 0; i--) begin                  // random read order
            j        = $urandom % (i + 1);
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < 3; i++) begin
            host_read({1'(ch), 2'(order[i])}, words[order[i]]);
        end
        note_seq(ch, words[2].status.seq, name);
        check_count({name, " period"}, words[0], 32'(row_ec[r] * row_per[r][ch]));
        check_count({name, " high"}, words[1], 32'(row_ec[r] * row_high[r][ch]));
        check_status(name, words[2].status, 1'(ch), 1'b0, row_high[r][ch] != 0);
    endtask

    task automatic drive_wave(input int ch);
        int p;
        int h;
        forever begin
            p = cur_per[ch];                                // shape latched per period
            h = cur_high[ch];
            @(posedge pll_clk);
            wave_in[ch] <= 1'b1;
            repeat (h - 1) @(posedge pll_clk);
            @(posedge pll_clk);
            wave_in[ch] <= 1'b0;
            repeat (p - h - 1) @(posedge pll_clk);
        end
    endtask

    initial begin
        wait (gen_go === 1'b1);
        drive_wave(0);
    end

    initial begin
        wait (gen_go === 1'b1);
        drive_wave(1);
    end

    // bound bus assertions count their failures
    always @(negedge pll_clk) begin
        if (UUT.u_wb_arbiter.u_checker.fail_count != 0) begin
            fail_run("an assertion on the shared result bus failed");
        end
    end

    // watchdog limit scales with the table
    initial begin
        longint lim;
        lim = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            lim += 3 * (row_ec[r] + 2) * ((row_per[r][0] > row_per[r][1]) ?
                   row_per[r][0] : row_per[r][1]) * 20;
        end
        lim = 2 * lim + 20000;                              // doubled plus fixed slack
        #(lim);
        fail_run("timeout: the measurement did not finish in time");
    end

    initial begin
        meas_word_u w;
        int         target [2];
        rnd        = $urandom(32'hae52);
        sys_rst_n  = 1'b0;
        wave_in    = '0;
        edge_count = 16'd1;
        host_req   = '0;
        gen_go     = 1'b0;
        last_seq   = '{0, 0};
        cur_per    = '{row_per[0][0], row_per[0][1]};
        cur_high   = '{row_high[0][0], row_high[0][1]};
        repeat (3) @(posedge pll_clk);
        sys_rst_n <= 1'b1;

        for (int a = 0; a < 8; a++) begin                  // bank clear after reset
            host_read(3'(a), w);
            check_count($sformatf("reset word %0d", a), w, 32'd0);
        end
        gen_go = 1'b1;

        for (int r = 0; r < N_ROWS; r++) begin
            @(posedge pll_clk);
            edge_count <= 16'(row_ec[r]);
            cur_per     = '{row_per[r][0], row_per[r][1]};
            cur_high    = '{row_high[r][0], row_high[r][1]};
            target      = '{last_seq[0] + 3, last_seq[1] + 3}; // skip straddling windows
            while (last_seq[0] < target[0] || last_seq[1] < target[1]) begin
                poll_status(0, row_name[r]);
                poll_status(1, row_name[r]);
            end
            read_slot(r, 0);
            read_slot(r, 1);
        end

        if (UUT.u_wb_arbiter.u_checker.fail_count != 0) begin
            fail_run("an assertion on the shared result bus failed");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule
